/* design/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_AW    = 6;
    localparam int REG_AW     = 5;
    localparam int WB_AW      = 8;

    // Debug address map, word addresses
    localparam logic [WB_AW-1:0] WB_IMEM_BASE = 8'h00;
    localparam logic [WB_AW-1:0] WB_REG_BASE  = 8'h40;
    localparam logic [WB_AW-1:0] WB_DMEM_BASE = 8'h80;
    localparam logic [WB_AW-1:0] WB_CTRL_ADDR = 8'hC0;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F     // Stops the core
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;     // Immediate as operand B
        logic    reg_dst;     // rd instead of rt
        logic    mem_to_reg;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

/* design/core_dbg_if.sv */
interface core_dbg_if;

    logic                             imem_we;
    logic [mips_pkg::IMEM_AW-1:0]     imem_addr;
    logic [mips_pkg::XLEN-1:0]        imem_wdata;
    logic [mips_pkg::REG_AW-1:0]      reg_raddr;
    logic [mips_pkg::XLEN-1:0]        reg_rdata;
    logic                             dmem_we;
    logic [mips_pkg::DMEM_AW-1:0]     dmem_addr;
    logic [mips_pkg::XLEN-1:0]        dmem_wdata;
    logic [mips_pkg::XLEN-1:0]        dmem_rdata;
    logic                             start;     // One-cycle run pulse
    logic                             halted;

    modport wb (
        output imem_we, imem_addr, imem_wdata, reg_raddr,
        output dmem_we, dmem_addr, dmem_wdata, start,
        input  reg_rdata, dmem_rdata, halted
    );

    modport core (
        input  imem_we, imem_addr, imem_wdata, reg_raddr,
        input  dmem_we, dmem_addr, dmem_wdata, start,
        output reg_rdata, dmem_rdata, halted
    );

endinterface

/* design/wb_debug_slave.sv */
module wb_debug_slave (
    input  logic                           clk_to_use,
    input  logic                           i_rst,
    input  logic                           i_wb_cyc,
    input  logic                           i_wb_stb,
    input  logic                           i_wb_we,
    input  logic [mips_pkg::WB_AW-1:0]     i_wb_adr,
    input  logic [mips_pkg::XLEN-1:0]      i_wb_dat,
    output logic [mips_pkg::XLEN-1:0]      o_wb_dat,
    output logic                           o_wb_ack,
    output logic                           o_running,
    core_dbg_if.wb                         dbg
);

    logic                        req;
    logic                        wr;
    logic                        sel_imem;
    logic                        sel_reg;
    logic                        sel_dmem;
    logic                        sel_ctrl;
    logic [mips_pkg::XLEN-1:0]   rdata;

    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;     // New access only
    assign wr  = req && i_wb_we;

    assign sel_imem = i_wb_adr[7:6] == mips_pkg::WB_IMEM_BASE[7:6];
    assign sel_reg  = i_wb_adr[7:5] == mips_pkg::WB_REG_BASE[7:5];   // Only 32 words
    assign sel_dmem = i_wb_adr[7:6] == mips_pkg::WB_DMEM_BASE[7:6];
    assign sel_ctrl = i_wb_adr == mips_pkg::WB_CTRL_ADDR;

    // Memory loads are locked out while a program runs
    assign dbg.imem_we    = wr && sel_imem && !o_running;
    assign dbg.imem_addr  = i_wb_adr[mips_pkg::IMEM_AW-1:0];
    assign dbg.imem_wdata = i_wb_dat;
    assign dbg.dmem_we    = wr && sel_dmem && !o_running;
    assign dbg.dmem_addr  = i_wb_adr[mips_pkg::DMEM_AW-1:0];
    assign dbg.dmem_wdata = i_wb_dat;
    assign dbg.reg_raddr  = i_wb_adr[mips_pkg::REG_AW-1:0];
    assign dbg.start      = wr && sel_ctrl && i_wb_dat[0] && !o_running;

    always_comb begin
        if (sel_reg) begin
            rdata = dbg.reg_rdata;
        end else if (sel_dmem) begin
            rdata = dbg.dmem_rdata;
        end else if (sel_ctrl) begin
            rdata = {{(mips_pkg::XLEN-2){1'b0}}, dbg.halted, o_running};
        end else begin
            rdata = '0;                                  // Imem and holes
        end
    end

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            o_wb_ack  <= 1'b0;
            o_wb_dat  <= '0;
            o_running <= 1'b0;
        end else begin
            o_wb_ack <= req;
            if (req) begin
                o_wb_dat <= rdata;
            end
            if (dbg.start) begin
                o_running <= 1'b1;
            end else if (dbg.halted) begin
                o_running <= 1'b0;                       // HALT retired
            end
        end
    end

endmodule

/* design/instr_fetch.sv */
module instr_fetch (
    input  logic                           clk_to_use,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  logic                           i_stall,
    input  logic                           i_redirect,
    input  logic [mips_pkg::IMEM_AW-1:0]   i_redirect_pc,
    input  logic                           i_fetch_en,
    output logic [mips_pkg::XLEN-1:0]      o_instr,
    output logic [mips_pkg::IMEM_AW-1:0]   o_pc_plus1,
    core_dbg_if.core                       dbg
);

    logic [mips_pkg::IMEM_AW-1:0] pc;
    logic [mips_pkg::XLEN-1:0]    imem [mips_pkg::IMEM_WORDS];

    always_ff @(posedge clk_to_use) begin
        if (dbg.imem_we) begin
            imem[dbg.imem_addr] <= dbg.imem_wdata;
        end
    end

    // PC and IF/ID, an all-zero word is the bubble
    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            pc         <= '0;
            o_instr    <= '0;
            o_pc_plus1 <= '0;
        end else if (i_start) begin
            pc         <= '0;
            o_instr    <= '0;
            o_pc_plus1 <= '0;
        end else if (!i_stall) begin
            if (i_redirect) begin
                pc      <= i_redirect_pc;
                o_instr <= '0;                           // Squash wrong-path slot
            end else if (i_fetch_en) begin
                pc         <= pc + 1'b1;
                o_instr    <= imem[pc];
                o_pc_plus1 <= pc + 1'b1;
            end else begin
                o_instr <= '0;
            end
        end
    end

endmodule

/* design/decode_stage.sv */
module decode_stage (
    input  logic                           clk_to_use,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  logic [mips_pkg::XLEN-1:0]      i_instr,
    input  logic [mips_pkg::IMEM_AW-1:0]   i_pc_plus1,
    input  logic                           i_wb_we,
    input  logic [mips_pkg::REG_AW-1:0]    i_wb_addr,
    input  logic [mips_pkg::XLEN-1:0]      i_wb_data,
    input  logic [mips_pkg::REG_AW-1:0]    i_ex_dst,
    input  logic                           i_ex_valid,
    input  logic [mips_pkg::REG_AW-1:0]    i_mem_dst,
    input  logic                           i_mem_valid,
    output mips_pkg::ctrl_t                o_ctrl,
    output logic [mips_pkg::XLEN-1:0]      o_rs_val,
    output logic [mips_pkg::XLEN-1:0]      o_rt_val,
    output logic [mips_pkg::XLEN-1:0]      o_imm,
    output logic [mips_pkg::REG_AW-1:0]    o_dst,
    output logic                           o_stall,
    output logic                           o_redirect,
    output logic [mips_pkg::IMEM_AW-1:0]   o_redirect_pc,
    output logic                           o_fetch_en,
    output logic                           o_halt_issued,
    core_dbg_if.core                       dbg
);

    logic [mips_pkg::XLEN-1:0]    regs [32];
    mips_pkg::opcode_e            op;
    mips_pkg::funct_e             fn;
    logic [mips_pkg::REG_AW-1:0]  rs;
    logic [mips_pkg::REG_AW-1:0]  rt;
    logic [mips_pkg::REG_AW-1:0]  rd;
    mips_pkg::ctrl_t              ctrl;
    logic                         uses_rs;
    logic                         uses_rt;
    logic                         take;
    logic                         is_halt;
    logic                         fetch_q;

    // Write-through read, r0 reads zero
    function automatic logic [mips_pkg::XLEN-1:0] rf_read(input logic [mips_pkg::REG_AW-1:0] a);
        if (a == '0) begin
            return '0;
        end
        if (i_wb_we && i_wb_addr == a) begin
            return i_wb_data;
        end
        return regs[a];
    endfunction

    assign op    = mips_pkg::opcode_e'(i_instr[31:26]);
    assign fn    = mips_pkg::funct_e'(i_instr[5:0]);
    assign rs    = i_instr[25:21];
    assign rt    = i_instr[20:16];
    assign rd    = i_instr[15:11];
    assign o_imm = {{16{i_instr[15]}}, i_instr[15:0]};

    always_comb begin
        o_rs_val = rf_read(rs);
        o_rt_val = rf_read(rt);
    end

    always_comb begin
        ctrl          = '0;
        uses_rs       = 1'b0;
        uses_rt       = 1'b0;
        take          = 1'b0;
        is_halt       = 1'b0;
        o_redirect_pc = i_pc_plus1 + o_imm[mips_pkg::IMEM_AW-1:0];
        case (op)
            mips_pkg::OP_RTYPE: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (fn)
                    mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    default:          ctrl.reg_write = 1'b0;   // Bubble lands here
                endcase
            end
            mips_pkg::OP_ADDI: begin
                uses_rs        = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                uses_rs         = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            mips_pkg::OP_SW: begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                take    = (o_rs_val == o_rt_val) ^ (op == mips_pkg::OP_BNE);
            end
            mips_pkg::OP_J: begin
                take          = 1'b1;
                o_redirect_pc = i_instr[mips_pkg::IMEM_AW-1:0];
            end
            mips_pkg::OP_HALT: is_halt = 1'b1;
            default: ;
        endcase
    end

    // Wait while a source is still in EX or MEM
    assign o_stall = (uses_rs && ((i_ex_valid && i_ex_dst == rs) ||
                                  (i_mem_valid && i_mem_dst == rs))) ||
                     (uses_rt && ((i_ex_valid && i_ex_dst == rt) ||
                                  (i_mem_valid && i_mem_dst == rt)));

    assign o_ctrl        = o_stall ? '0 : ctrl;
    assign o_dst         = ctrl.reg_dst ? rd : rt;
    assign o_redirect    = take && !o_stall;
    assign o_halt_issued = is_halt && !o_stall;
    assign o_fetch_en    = fetch_q && !is_halt;
    assign dbg.reg_rdata = regs[dbg.reg_raddr];

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            regs    <= '{default: '0};
            fetch_q <= 1'b0;
        end else if (i_start) begin
            regs    <= '{default: '0};       // Every run starts clean
            fetch_q <= 1'b1;
        end else begin
            if (i_wb_we && i_wb_addr != '0) begin
                regs[i_wb_addr] <= i_wb_data;
            end
            if (is_halt) begin
                fetch_q <= 1'b0;
            end
        end
    end

endmodule

/* design/exec_mem_wb.sv */
module exec_mem_wb (
    input  logic                           clk_to_use,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  mips_pkg::ctrl_t                i_ctrl,
    input  logic [mips_pkg::XLEN-1:0]      i_rs_val,
    input  logic [mips_pkg::XLEN-1:0]      i_rt_val,
    input  logic [mips_pkg::XLEN-1:0]      i_imm,
    input  logic [mips_pkg::REG_AW-1:0]    i_dst,
    input  logic                           i_halt_issued,
    output logic [mips_pkg::REG_AW-1:0]    o_ex_dst,
    output logic                           o_ex_valid,
    output logic [mips_pkg::REG_AW-1:0]    o_mem_dst,
    output logic                           o_mem_valid,
    output logic                           o_wb_we,
    output logic [mips_pkg::REG_AW-1:0]    o_wb_addr,
    output logic [mips_pkg::XLEN-1:0]      o_wb_data,
    core_dbg_if.core                       dbg
);

    mips_pkg::ctrl_t             ex_ctrl;
    mips_pkg::ctrl_t             mem_ctrl;
    mips_pkg::ctrl_t             wb_ctrl;
    logic                        ex_halt;
    logic                        mem_halt;
    logic                        wb_halt;
    logic                        halted_q;
    logic [mips_pkg::XLEN-1:0]   ex_rs;
    logic [mips_pkg::XLEN-1:0]   ex_rt;
    logic [mips_pkg::XLEN-1:0]   ex_imm;
    logic [mips_pkg::XLEN-1:0]   alu_b;
    logic [mips_pkg::XLEN-1:0]   alu_y;
    logic [mips_pkg::XLEN-1:0]   mem_alu;
    logic [mips_pkg::XLEN-1:0]   mem_wdata;
    logic [mips_pkg::XLEN-1:0]   mem_rdata;
    logic [mips_pkg::XLEN-1:0]   wb_alu;
    logic [mips_pkg::XLEN-1:0]   wb_rdata;
    logic [mips_pkg::XLEN-1:0]   dmem [mips_pkg::DMEM_WORDS];

    assign alu_b = ex_ctrl.alu_src ? ex_imm : ex_rt;

    always_comb begin
        case (ex_ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_y = ex_rs + alu_b;
            mips_pkg::ALU_SUB: alu_y = ex_rs - alu_b;
            mips_pkg::ALU_AND: alu_y = ex_rs & alu_b;
            mips_pkg::ALU_OR:  alu_y = ex_rs | alu_b;
            mips_pkg::ALU_SLT: alu_y = {{(mips_pkg::XLEN-1){1'b0}}, $signed(ex_rs) < $signed(alu_b)};
            default:           alu_y = '0;
        endcase
    end

    // Word addressed, wraps on the low bits
    assign mem_rdata = mem_ctrl.mem_read ? dmem[mem_alu[mips_pkg::DMEM_AW-1:0]] : '0;
    assign dbg.dmem_rdata = dmem[dbg.dmem_addr];

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            dmem <= '{default: '0};
        end else if (mem_ctrl.mem_write) begin
            dmem[mem_alu[mips_pkg::DMEM_AW-1:0]] <= mem_wdata;
        end else if (dbg.dmem_we) begin
            dmem[dbg.dmem_addr] <= dbg.dmem_wdata;
        end
    end

    always_ff @(posedge clk_to_use or posedge i_rst) begin
        if (i_rst) begin
            {ex_ctrl, mem_ctrl, wb_ctrl} <= '0;
            {ex_halt, mem_halt, wb_halt} <= '0;
            halted_q <= 1'b0;
        end else if (i_start) begin
            {ex_ctrl, mem_ctrl, wb_ctrl} <= '0;
            {ex_halt, mem_halt, wb_halt} <= '0;
            halted_q <= 1'b0;
        end else begin
            ex_ctrl  <= i_ctrl;
            ex_halt  <= i_halt_issued;
            mem_ctrl <= ex_ctrl;
            mem_halt <= ex_halt;
            wb_ctrl  <= mem_ctrl;
            wb_halt  <= mem_halt;
            if (wb_halt) begin
                halted_q <= 1'b1;                        // Sticky until next start
            end
        end
    end

    always_ff @(posedge clk_to_use) begin
        ex_rs     <= i_rs_val;
        ex_rt     <= i_rt_val;
        ex_imm    <= i_imm;
        o_ex_dst  <= i_dst;
        mem_alu   <= alu_y;
        mem_wdata <= ex_rt;
        o_mem_dst <= o_ex_dst;
        wb_alu    <= mem_alu;
        wb_rdata  <= mem_rdata;
        o_wb_addr <= o_mem_dst;
    end

    assign o_ex_valid  = ex_ctrl.reg_write && o_ex_dst != '0;
    assign o_mem_valid = mem_ctrl.reg_write && o_mem_dst != '0;
    assign o_wb_we     = wb_ctrl.reg_write;
    assign o_wb_data   = wb_ctrl.mem_to_reg ? wb_rdata : wb_alu;
    assign dbg.halted  = halted_q;

endmodule

/* design/mips_top.sv */
module mips_top (
    input  logic                           clk_to_use,
    input  logic                           i_rst,
    input  logic                           i_wb_cyc,
    input  logic                           i_wb_stb,
    input  logic                           i_wb_we,
    input  logic [mips_pkg::WB_AW-1:0]     i_wb_adr,
    input  logic [mips_pkg::XLEN-1:0]      i_wb_dat,
    output logic [mips_pkg::XLEN-1:0]      o_wb_dat,
    output logic                           o_wb_ack,
    output logic                           o_running,
    output logic                           o_halted
);

    core_dbg_if dbg_bus ();

    logic [mips_pkg::XLEN-1:0]    if_instr;
    logic [mips_pkg::IMEM_AW-1:0] if_pc_plus1;
    logic                         id_stall;
    logic                         id_redirect;
    logic [mips_pkg::IMEM_AW-1:0] id_redirect_pc;
    logic                         id_fetch_en;
    mips_pkg::ctrl_t              id_ctrl;
    logic [mips_pkg::XLEN-1:0]    id_rs_val;
    logic [mips_pkg::XLEN-1:0]    id_rt_val;
    logic [mips_pkg::XLEN-1:0]    id_imm;
    logic [mips_pkg::REG_AW-1:0]  id_dst;
    logic                         id_halt_issued;
    logic [mips_pkg::REG_AW-1:0]  ex_dst;
    logic                         ex_valid;
    logic [mips_pkg::REG_AW-1:0]  mem_dst;
    logic                         mem_valid;
    logic                         wb_we;
    logic [mips_pkg::REG_AW-1:0]  wb_addr;
    logic [mips_pkg::XLEN-1:0]    wb_data;

    assign o_halted = dbg_bus.halted;

    wb_debug_slave u_slave (
        .clk_to_use, .i_rst, .i_wb_cyc, .i_wb_stb, .i_wb_we, .i_wb_adr, .i_wb_dat,
        .o_wb_dat, .o_wb_ack, .o_running, .dbg(dbg_bus.wb)
    );

    instr_fetch u_if (
        .clk_to_use, .i_rst, .i_start(dbg_bus.start), .i_stall(id_stall),
        .i_redirect(id_redirect), .i_redirect_pc(id_redirect_pc), .i_fetch_en(id_fetch_en),
        .o_instr(if_instr), .o_pc_plus1(if_pc_plus1), .dbg(dbg_bus.core)
    );

    decode_stage u_id (
        .clk_to_use, .i_rst, .i_start(dbg_bus.start), .i_instr(if_instr),
        .i_pc_plus1(if_pc_plus1), .i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .i_ex_dst(ex_dst), .i_ex_valid(ex_valid), .i_mem_dst(mem_dst), .i_mem_valid(mem_valid),
        .o_ctrl(id_ctrl), .o_rs_val(id_rs_val), .o_rt_val(id_rt_val), .o_imm(id_imm),
        .o_dst(id_dst), .o_stall(id_stall), .o_redirect(id_redirect),
        .o_redirect_pc(id_redirect_pc), .o_fetch_en(id_fetch_en),
        .o_halt_issued(id_halt_issued), .dbg(dbg_bus.core)
    );

    exec_mem_wb u_ex (
        .clk_to_use, .i_rst, .i_start(dbg_bus.start), .i_ctrl(id_ctrl),
        .i_rs_val(id_rs_val), .i_rt_val(id_rt_val), .i_imm(id_imm), .i_dst(id_dst),
        .i_halt_issued(id_halt_issued), .o_ex_dst(ex_dst), .o_ex_valid(ex_valid),
        .o_mem_dst(mem_dst), .o_mem_valid(mem_valid), .o_wb_we(wb_we),
        .o_wb_addr(wb_addr), .o_wb_data(wb_data), .dbg(dbg_bus.core)
    );

endmodule

/* tests/tb_mips_model.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

logic [31:0] prog [64];      // Program image, HALT at prog_len-1
int          prog_len;
logic [31:0] m_regs [32];
logic [31:0] m_dmem [64];    // Shadow of the DUT data memory

function automatic logic [31:0] enc_r(mips_pkg::funct_e fn, logic [4:0] rd, logic [4:0] rs,
                                      logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'h00, fn};
endfunction

function automatic logic [31:0] enc_i(mips_pkg::opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                      logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(7, 0));      // Small set keeps dependencies dense
endfunction

function automatic mips_pkg::funct_e pick_funct();
    case ($urandom_range(4, 0))
        0: return mips_pkg::FN_ADD;
        1: return mips_pkg::FN_SUB;
        2: return mips_pkg::FN_AND;
        3: return mips_pkg::FN_OR;
        default: return mips_pkg::FN_SLT;
    endcase
endfunction

// Kind 0 is ALU only, 1 adds loads and stores, 2 adds branches and jumps
function automatic void gen_program(int kind);
    int         sel;
    int         tgt;
    logic [4:0] src;
    logic [4:0] dst;
    logic [4:0] last;
    prog_len = $urandom_range(40, 12);
    last = 5'd1;
    for (int i = 0; i < prog_len - 1; i++) begin
        sel = $urandom_range(9, 0);
        src = ($urandom_range(1, 0) == 1) ? last : pick_reg();
        dst = pick_reg();
        if (kind == 1 && sel < 3) begin
            prog[i] = enc_i(mips_pkg::OP_LW, src, dst, 16'($urandom_range(63, 0)));
            last = dst;                                     // Next one often uses the load
        end else if (kind == 1 && sel < 5) begin
            prog[i] = enc_i(mips_pkg::OP_SW, pick_reg(), last, 16'($urandom_range(63, 0)));
        end else if (kind == 2 && sel < 4) begin
            tgt = $urandom_range(prog_len - 1, i + 1);      // Forward only
            case (sel)
                0: prog[i] = {mips_pkg::OP_J, 20'h0, 6'(tgt)};
                1: prog[i] = enc_i(mips_pkg::OP_BEQ, src, src, 16'(tgt - i - 1));
                2: prog[i] = enc_i(mips_pkg::OP_BNE, src, pick_reg(), 16'(tgt - i - 1));
                default: prog[i] = enc_i(mips_pkg::OP_BEQ, src, pick_reg(), 16'(tgt - i - 1));
            endcase
        end else if (sel < 7) begin
            prog[i] = enc_r(pick_funct(), dst, src, last);
            last = dst;
        end else begin
            prog[i] = enc_i(mips_pkg::OP_ADDI, src, dst, 16'($urandom));
            last = dst;
        end
    end
    prog[prog_len - 1] = {mips_pkg::OP_HALT, 26'h0};
endfunction

// One instruction at a time, no pipeline
function automatic void model_run();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    logic [5:0]  pc;
    foreach (m_regs[r]) begin
        m_regs[r] = '0;                     // Each run starts with a clean register file
    end
    pc = '0;
    for (int step = 0; step < 256; step++) begin
        ins = prog[pc];
        a   = m_regs[ins[25:21]];
        b   = m_regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        ea  = a + imm;
        res = '0;
        dst = ins[20:16];
        wr  = 1'b0;
        pc  = pc + 6'd1;
        case (ins[31:26])
            mips_pkg::OP_HALT: return;
            mips_pkg::OP_RTYPE: begin
                wr  = 1'b1;
                dst = ins[15:11];
                case (ins[5:0])
                    mips_pkg::FN_ADD: res = a + b;
                    mips_pkg::FN_SUB: res = a - b;
                    mips_pkg::FN_AND: res = a & b;
                    mips_pkg::FN_OR:  res = a | b;
                    mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                wr  = 1'b1;
                res = ea;
            end
            mips_pkg::OP_LW: begin
                wr  = 1'b1;
                res = m_dmem[ea[5:0]];              // Wraps at 64 words
            end
            mips_pkg::OP_SW: m_dmem[ea[5:0]] = b;
            mips_pkg::OP_BEQ: pc = (a == b) ? pc + imm[5:0] : pc;
            mips_pkg::OP_BNE: pc = (a != b) ? pc + imm[5:0] : pc;
            mips_pkg::OP_J: pc = ins[5:0];
            default: ;
        endcase
        if (wr && dst != 5'd0) begin
            m_regs[dst] = res;
        end
    end
endfunction

`endif

/* tests/tb_mips.sv */
module tb_mips;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PROGS   = 40;
    localparam int WB_PER_PROG = 64 + 64 + 64 + 32 + 8;
    localparam int CYCLE_LIMIT = NUM_PROGS * 64 * 4 + NUM_PROGS * WB_PER_PROG * 2 + 2000;

    logic        clk_to_use;
    logic        i_rst;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [7:0]  i_wb_adr;
    logic [31:0] i_wb_dat;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;
    logic        o_running;
    logic        o_halted;

    int cycle_count = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_base = 0;

    `include "tb_mips_model.svh"

    mips_top i_dut (
        .clk_to_use(clk_to_use), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat),
        .o_wb_ack(o_wb_ack), .o_running(o_running), .o_halted(o_halted)
    );

    always #4 clk_to_use = ~clk_to_use;

    always @(posedge clk_to_use) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Simulation stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Classic cycle, held until ack
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        @(negedge clk_to_use);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = wdat;
        waited   = 0;
        rdat     = 'x;
        do begin
            @(negedge clk_to_use);
            waited++;
        end while (!o_wb_ack && waited < 16);
        if (o_wb_ack) begin
            rdat = o_wb_dat;
        end else begin
            errors++;
            $display("Wishbone access at address 0x%02h was never acknowledged", adr);
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] discard;
        wb_access(1'b1, adr, dat, discard);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic expect_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - test_base);
        end
        test_base = errors;
    endtask

    task automatic check_all_regs();
        logic [31:0] rd;
        for (int r = 0; r < 32; r++) begin
            wb_read(mips_pkg::WB_REG_BASE + 8'(r), rd);
            expect_word($sformatf("r%0d", r), m_regs[r], rd);
        end
    endtask

    task automatic check_all_dmem();
        logic [31:0] rd;
        for (int a = 0; a < 64; a++) begin
            wb_read(mips_pkg::WB_DMEM_BASE + 8'(a), rd);
            expect_word($sformatf("dmem[%0d]", a), m_dmem[a], rd);
        end
    endtask

    task automatic run_program(input bit with_dmem);
        logic [31:0] rd;
        int          polls;
        for (int i = 0; i < prog_len; i++) begin
            wb_write(mips_pkg::WB_IMEM_BASE + 8'(i), prog[i]);
        end
        model_run();
        wb_write(mips_pkg::WB_CTRL_ADDR, 32'h1);
        wb_read(mips_pkg::WB_CTRL_ADDR, rd);
        expect_word("ctrl word", 32'h1, rd);         // Running, halted cleared by start
        expect_word("o_running", 32'h1, {31'h0, o_running});
        polls = 0;
        while (rd[1] !== 1'b1 && polls < 300) begin
            wb_read(mips_pkg::WB_CTRL_ADDR, rd);
            polls++;
        end
        if (rd[1] !== 1'b1) begin
            errors++;
            $display("Program of %0d words never reached halt", prog_len);
        end
        wb_read(mips_pkg::WB_CTRL_ADDR, rd);
        expect_word("ctrl word", 32'h2, rd);         // Halted and no longer running
        expect_word("o_halted", 32'h1, {31'h0, o_halted});
        expect_word("o_running", 32'h0, {31'h0, o_running});
        check_all_regs();
        if (with_dmem) begin
            check_all_dmem();
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        logic [7:0]  adr;
        void'($urandom(22));
        clk_to_use = 1'b0;
        i_rst      = 1'b1;
        i_wb_cyc   = 1'b0;
        i_wb_stb   = 1'b0;
        i_wb_we    = 1'b0;
        i_wb_adr   = '0;
        i_wb_dat   = '0;
        foreach (m_dmem[a]) begin
            m_dmem[a] = '0;
        end
        foreach (m_regs[r]) begin
            m_regs[r] = '0;
        end
        repeat (2) @(negedge clk_to_use);
        i_rst = 1'b0;

        wb_read(mips_pkg::WB_CTRL_ADDR, rd);
        expect_word("ctrl word", 32'h0, rd);
        expect_word("o_running", 32'h0, {31'h0, o_running});
        expect_word("o_halted", 32'h0, {31'h0, o_halted});
        check_all_regs();
        check_all_dmem();
        finish_test("reset state");

        for (int a = 0; a < 64; a++) begin
            val = $urandom;
            wb_write(mips_pkg::WB_DMEM_BASE + 8'(a), val);
            m_dmem[a] = val;
        end
        check_all_dmem();
        for (int k = 0; k < 4; k++) begin
            adr = 8'h60 + 8'($urandom_range(31, 0));     // Hole above the registers
            wb_read(adr, rd);
            expect_word($sformatf("o_wb_dat at 0x%02h", adr), 32'h0, rd);
            adr = 8'hC1 + 8'($urandom_range(62, 0));
            wb_read(adr, rd);
            expect_word($sformatf("o_wb_dat at 0x%02h", adr), 32'h0, rd);
        end
        finish_test("dmem round trip");

        repeat (12) begin
            gen_program(0);
            run_program(1'b0);
        end
        finish_test("ALU programs");

        repeat (12) begin
            gen_program(1);
            run_program(1'b1);
        end
        finish_test("memory programs");

        repeat (12) begin
            gen_program(2);
            run_program(1'b0);
        end
        finish_test("control flow");

        repeat (4) begin
            gen_program($urandom_range(2, 0));
            run_program(1'b1);
        end
        finish_test("rerun after halt");

        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* mips_top.f */
+incdir+tests
design/mips_pkg.sv
design/core_dbg_if.sv
design/wb_debug_slave.sv
design/instr_fetch.sv
design/decode_stage.sv
design/exec_mem_wb.sv
design/mips_top.sv
tests/tb_mips.sv

/* Makefile */
# Verilator build and run for the pipelined MIPS core

VERILATOR ?= verilator
TOP       ?= tb_mips
FILELIST  ?= mips_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
